// ==== Makefile ====
VERILATOR = verilator
TOP       = tb_exec_top
FILELIST  = src.f
FLAGS     = --binary --assert -j 0
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The pass line in the simulation output decides the exit status
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/alu_exec.sv ====
`timescale 1ns/100ps

module alu_exec (
    input  logic      clk,
    input  logic      rst,
    dec_exe_if.sink   dec,
    exe_res_if.source exe
);

    logic [exec_pkg::XLEN-1:0]   sum, diff, result;
    logic [2*exec_pkg::XLEN-1:0] hilo;
    logic                        overflow;
    logic                        is_md, md_started, md_ready;
    logic                        start, busy, done;
    logic                        slot_free, fire;
    exec_pkg::md_op_e            cmd;

    function automatic logic [5:0] lead_count(input logic [31:0] v, input logic bit_val);
        logic [5:0] n;
        logic       stop;
        n    = '0;
        stop = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!stop && v[i] == bit_val)
                n = n + 6'd1;
            else
                stop = 1'b1;
        end
        return n;
    endfunction

    assign sum  = dec.src_a + dec.src_b;
    assign diff = dec.src_a - dec.src_b;

    always_comb begin
        case (dec.op)
            exec_pkg::OP_ADD, exec_pkg::OP_ADDU: result = sum;
            exec_pkg::OP_SUB, exec_pkg::OP_SUBU: result = diff;
            exec_pkg::OP_AND:  result = dec.src_a & dec.src_b;
            exec_pkg::OP_OR:   result = dec.src_a | dec.src_b;
            exec_pkg::OP_XOR:  result = dec.src_a ^ dec.src_b;
            exec_pkg::OP_NOR:  result = ~(dec.src_a | dec.src_b);
            exec_pkg::OP_SLT:  result = {31'd0, $signed(dec.src_a) < $signed(dec.src_b)};
            exec_pkg::OP_SLTU: result = {31'd0, dec.src_a < dec.src_b};
            exec_pkg::OP_SLL:  result = dec.src_b << dec.src_a[4:0];
            exec_pkg::OP_SRL:  result = dec.src_b >> dec.src_a[4:0];
            exec_pkg::OP_SRA:  result = $signed(dec.src_b) >>> dec.src_a[4:0];
            exec_pkg::OP_LUI:  result = {dec.src_b[15:0], 16'h0000};
            exec_pkg::OP_CLZ:  result = {26'd0, lead_count(dec.src_a, 1'b0)};
            exec_pkg::OP_CLO:  result = {26'd0, lead_count(dec.src_a, 1'b1)};
            exec_pkg::OP_MTHI, exec_pkg::OP_MTLO: result = dec.src_a;
            default:           result = '0;
        endcase
    end

    // Signed overflow for ADD/ADDI and SUB only
    always_comb begin
        case (dec.op)
            exec_pkg::OP_ADD:
                overflow = (dec.src_a[31] ~^ dec.src_b[31]) & (dec.src_a[31] ^ sum[31]);
            exec_pkg::OP_SUB:
                overflow = (dec.src_a[31] ^ dec.src_b[31]) & (dec.src_a[31] ^ diff[31]);
            default:
                overflow = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.op)
            exec_pkg::OP_MULTU: cmd = exec_pkg::MD_MULU;
            exec_pkg::OP_DIV:   cmd = exec_pkg::MD_DIV;
            exec_pkg::OP_DIVU:  cmd = exec_pkg::MD_DIVU;
            default:            cmd = exec_pkg::MD_MUL;
        endcase
    end

    assign is_md = dec.op inside {exec_pkg::OP_MULT, exec_pkg::OP_MULTU,
                                  exec_pkg::OP_DIV, exec_pkg::OP_DIVU};

    // Launch once per instruction, then hold it until the unit reports done
    assign start     = dec.valid && is_md && !md_started;
    assign slot_free = !exe.valid || exe.ready;
    assign dec.ready = slot_free && (!is_md || md_ready || done);
    assign fire      = dec.valid && dec.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            md_started <= 1'b0;
            md_ready   <= 1'b0;
        end else if (fire) begin
            md_started <= 1'b0;
            md_ready   <= 1'b0;
        end else begin
            if (start)
                md_started <= 1'b1;
            if (done)
                md_ready <= 1'b1;
        end
    end

    mul_div_unit u_mul_div (
        .clk  (clk),
        .rst  (rst),
        .start(start),
        .cmd  (cmd),
        .a    (dec.src_a),
        .b    (dec.src_b),
        .busy (busy),
        .done (done),
        .hilo (hilo)
    );

    always_ff @(posedge clk) begin
        if (rst)
            exe.valid <= 1'b0;
        else if (slot_free)
            exe.valid <= fire;
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            exe.op       <= dec.op;
            exe.value    <= result;
            exe.product  <= hilo;
            exe.overflow <= overflow;
            exe.dest     <= dec.dest;
        end
    end

    assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

// ==== hw/exec_ifs.sv ====
`timescale 1ns/100ps

interface dec_exe_if;
    logic                                valid;
    logic                                ready;
    exec_pkg::alu_op_e                   op;
    logic [exec_pkg::XLEN-1:0]           src_a;
    logic [exec_pkg::XLEN-1:0]           src_b;
    logic [exec_pkg::REG_W-1:0]          dest;

    modport source (
        output valid, op, src_a, src_b, dest,
        input  ready
    );

    modport sink (
        input  valid, op, src_a, src_b, dest,
        output ready
    );
endinterface

interface exe_res_if;
    logic                                valid;
    logic                                ready;
    exec_pkg::alu_op_e                   op;
    logic [exec_pkg::XLEN-1:0]           value;
    logic [2*exec_pkg::XLEN-1:0]         product;
    logic                                overflow;
    logic [exec_pkg::REG_W-1:0]          dest;

    modport source (
        output valid, op, value, product, overflow, dest,
        input  ready
    );

    modport sink (
        input  valid, op, value, product, overflow, dest,
        output ready
    );
endinterface

// ==== hw/exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;
    localparam int OPC_W = 6;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_CLZ,
        OP_CLO,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_MULT,
        OP_MULTU,
        OP_DIV,
        OP_DIVU
    } alu_op_e;

    typedef enum logic [1:0] {
        MD_MUL,
        MD_MULU,
        MD_DIV,
        MD_DIVU
    } md_op_e;

    // Major opcodes
    localparam logic [OPC_W-1:0] OPC_SPECIAL  = 6'h00;
    localparam logic [OPC_W-1:0] OPC_SPECIAL2 = 6'h1c;
    localparam logic [OPC_W-1:0] OPC_ADDI     = 6'h08;
    localparam logic [OPC_W-1:0] OPC_ADDIU    = 6'h09;
    localparam logic [OPC_W-1:0] OPC_SLTI     = 6'h0a;
    localparam logic [OPC_W-1:0] OPC_ANDI     = 6'h0c;
    localparam logic [OPC_W-1:0] OPC_ORI      = 6'h0d;
    localparam logic [OPC_W-1:0] OPC_XORI     = 6'h0e;
    localparam logic [OPC_W-1:0] OPC_LUI      = 6'h0f;

    // Funct codes under SPECIAL
    localparam logic [OPC_W-1:0] FN_SLL   = 6'h00;
    localparam logic [OPC_W-1:0] FN_SRL   = 6'h02;
    localparam logic [OPC_W-1:0] FN_SRA   = 6'h03;
    localparam logic [OPC_W-1:0] FN_MFHI  = 6'h10;
    localparam logic [OPC_W-1:0] FN_MTHI  = 6'h11;
    localparam logic [OPC_W-1:0] FN_MFLO  = 6'h12;
    localparam logic [OPC_W-1:0] FN_MTLO  = 6'h13;
    localparam logic [OPC_W-1:0] FN_MULT  = 6'h18;
    localparam logic [OPC_W-1:0] FN_MULTU = 6'h19;
    localparam logic [OPC_W-1:0] FN_DIV   = 6'h1a;
    localparam logic [OPC_W-1:0] FN_DIVU  = 6'h1b;
    localparam logic [OPC_W-1:0] FN_ADD   = 6'h20;
    localparam logic [OPC_W-1:0] FN_ADDU  = 6'h21;
    localparam logic [OPC_W-1:0] FN_SUB   = 6'h22;
    localparam logic [OPC_W-1:0] FN_SUBU  = 6'h23;
    localparam logic [OPC_W-1:0] FN_AND   = 6'h24;
    localparam logic [OPC_W-1:0] FN_OR    = 6'h25;
    localparam logic [OPC_W-1:0] FN_XOR   = 6'h26;
    localparam logic [OPC_W-1:0] FN_NOR   = 6'h27;
    localparam logic [OPC_W-1:0] FN_SLT   = 6'h2a;
    localparam logic [OPC_W-1:0] FN_SLTU  = 6'h2b;

    // Funct codes under SPECIAL2
    localparam logic [OPC_W-1:0] FN_CLZ = 6'h20;
    localparam logic [OPC_W-1:0] FN_CLO = 6'h21;

endpackage

// ==== hw/exec_top.sv ====
`timescale 1ns/100ps

module exec_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] in_instr,
    input  logic [31:0] in_rs_val,
    input  logic [31:0] in_rt_val,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [4:0]  out_dest,
    output logic        out_wen,
    output logic [31:0] out_data,
    output logic        out_overflow
);

    dec_exe_if u_dec_if ();
    exe_res_if u_exe_if ();

    inst_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .in_rs_val(in_rs_val),
        .in_rt_val(in_rt_val),
        .dec      (u_dec_if.source)
    );

    alu_exec u_exec (
        .clk(clk),
        .rst(rst),
        .dec(u_dec_if.sink),
        .exe(u_exe_if.source)
    );

    hilo_commit u_commit (
        .clk         (clk),
        .rst         (rst),
        .exe         (u_exe_if.sink),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_dest    (out_dest),
        .out_wen     (out_wen),
        .out_data    (out_data),
        .out_overflow(out_overflow)
    );

endmodule

// ==== hw/hilo_commit.sv ====
`timescale 1ns/100ps

module hilo_commit (
    input  logic                       clk,
    input  logic                       rst,
    exe_res_if.sink                    exe,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [exec_pkg::REG_W-1:0] out_dest,
    output logic                       out_wen,
    output logic [exec_pkg::XLEN-1:0]  out_data,
    output logic                       out_overflow
);

    logic [exec_pkg::XLEN-1:0] hi, lo;
    logic                      fire;

    assign exe.ready = !out_valid || out_ready;
    assign fire      = exe.valid && exe.ready;

    // Stages are in order, so HI/LO are always current when MFHI/MFLO arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (fire) begin
            case (exe.op)
                exec_pkg::OP_MULT, exec_pkg::OP_MULTU,
                exec_pkg::OP_DIV, exec_pkg::OP_DIVU: begin
                    hi <= exe.product[63:32];
                    lo <= exe.product[31:0];
                end
                exec_pkg::OP_MTHI: hi <= exe.value;
                exec_pkg::OP_MTLO: lo <= exe.value;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else if (exe.ready)
            out_valid <= exe.valid;
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_dest     <= exe.dest;
            out_wen      <= (exe.dest != '0) && !exe.overflow;
            out_overflow <= exe.overflow;
            case (exe.op)
                exec_pkg::OP_MFHI: out_data <= hi;
                exec_pkg::OP_MFLO: out_data <= lo;
                default:           out_data <= exe.value;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=>
            out_valid && $stable({out_dest, out_wen, out_data, out_overflow}));

endmodule

// ==== hw/inst_decode.sv ====
`timescale 1ns/100ps

module inst_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [31:0]               in_instr,
    input  logic [exec_pkg::XLEN-1:0] in_rs_val,
    input  logic [exec_pkg::XLEN-1:0] in_rt_val,
    dec_exe_if.source                 dec
);

    logic [5:0]                        opcode, funct;
    logic [4:0]                        rt, rd, shamt;
    logic [15:0]                       imm;
    exec_pkg::alu_op_e                 op_n;
    logic [exec_pkg::XLEN-1:0]         a_n, b_n;
    logic [exec_pkg::REG_W-1:0]        dest_n;
    logic                              r_type;

    assign opcode    = in_instr[31:26];
    assign rt        = in_instr[20:16];
    assign rd        = in_instr[15:11];
    assign shamt     = in_instr[10:6];
    assign funct     = in_instr[5:0];
    assign imm       = in_instr[15:0];
    assign r_type    = (opcode == exec_pkg::OPC_SPECIAL) || (opcode == exec_pkg::OPC_SPECIAL2);

    always_comb begin
        op_n = exec_pkg::OP_NOP;
        if (opcode == exec_pkg::OPC_SPECIAL) begin
            case (funct)
                exec_pkg::FN_SLL:   op_n = exec_pkg::OP_SLL;
                exec_pkg::FN_SRL:   op_n = exec_pkg::OP_SRL;
                exec_pkg::FN_SRA:   op_n = exec_pkg::OP_SRA;
                exec_pkg::FN_MFHI:  op_n = exec_pkg::OP_MFHI;
                exec_pkg::FN_MTHI:  op_n = exec_pkg::OP_MTHI;
                exec_pkg::FN_MFLO:  op_n = exec_pkg::OP_MFLO;
                exec_pkg::FN_MTLO:  op_n = exec_pkg::OP_MTLO;
                exec_pkg::FN_MULT:  op_n = exec_pkg::OP_MULT;
                exec_pkg::FN_MULTU: op_n = exec_pkg::OP_MULTU;
                exec_pkg::FN_DIV:   op_n = exec_pkg::OP_DIV;
                exec_pkg::FN_DIVU:  op_n = exec_pkg::OP_DIVU;
                exec_pkg::FN_ADD:   op_n = exec_pkg::OP_ADD;
                exec_pkg::FN_ADDU:  op_n = exec_pkg::OP_ADDU;
                exec_pkg::FN_SUB:   op_n = exec_pkg::OP_SUB;
                exec_pkg::FN_SUBU:  op_n = exec_pkg::OP_SUBU;
                exec_pkg::FN_AND:   op_n = exec_pkg::OP_AND;
                exec_pkg::FN_OR:    op_n = exec_pkg::OP_OR;
                exec_pkg::FN_XOR:   op_n = exec_pkg::OP_XOR;
                exec_pkg::FN_NOR:   op_n = exec_pkg::OP_NOR;
                exec_pkg::FN_SLT:   op_n = exec_pkg::OP_SLT;
                exec_pkg::FN_SLTU:  op_n = exec_pkg::OP_SLTU;
                default:            op_n = exec_pkg::OP_NOP;
            endcase
        end else if (opcode == exec_pkg::OPC_SPECIAL2) begin
            if (funct == exec_pkg::FN_CLZ)
                op_n = exec_pkg::OP_CLZ;
            else if (funct == exec_pkg::FN_CLO)
                op_n = exec_pkg::OP_CLO;
        end else begin
            case (opcode)
                exec_pkg::OPC_ADDI:  op_n = exec_pkg::OP_ADD;
                exec_pkg::OPC_ADDIU: op_n = exec_pkg::OP_ADDU;
                exec_pkg::OPC_SLTI:  op_n = exec_pkg::OP_SLT;
                exec_pkg::OPC_ANDI:  op_n = exec_pkg::OP_AND;
                exec_pkg::OPC_ORI:   op_n = exec_pkg::OP_OR;
                exec_pkg::OPC_XORI:  op_n = exec_pkg::OP_XOR;
                exec_pkg::OPC_LUI:   op_n = exec_pkg::OP_LUI;
                default:             op_n = exec_pkg::OP_NOP;
            endcase
        end
    end

    // Operand and destination selection
    always_comb begin
        a_n    = in_rs_val;
        b_n    = in_rt_val;
        dest_n = r_type ? rd : rt;
        if (op_n inside {exec_pkg::OP_SLL, exec_pkg::OP_SRL, exec_pkg::OP_SRA})
            a_n = {27'd0, shamt};
        if (!r_type) begin
            if (opcode inside {exec_pkg::OPC_ANDI, exec_pkg::OPC_ORI, exec_pkg::OPC_XORI})
                b_n = {16'd0, imm};
            else
                b_n = {{16{imm[15]}}, imm};
        end
        if (op_n inside {exec_pkg::OP_NOP, exec_pkg::OP_MTHI, exec_pkg::OP_MTLO,
                         exec_pkg::OP_MULT, exec_pkg::OP_MULTU,
                         exec_pkg::OP_DIV, exec_pkg::OP_DIVU})
            dest_n = '0;
    end

    assign in_ready = !dec.valid || dec.ready;

    always_ff @(posedge clk) begin
        if (rst)
            dec.valid <= 1'b0;
        else if (in_ready)
            dec.valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec.op    <= op_n;
            dec.src_a <= a_n;
            dec.src_b <= b_n;
            dec.dest  <= dest_n;
        end
    end

endmodule

// ==== hw/mul_div_unit.sv ====
`timescale 1ns/100ps

module mul_div_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  exec_pkg::md_op_e            cmd,
    input  logic [exec_pkg::XLEN-1:0]   a,
    input  logic [exec_pkg::XLEN-1:0]   b,
    output logic                        busy,
    output logic                        done,
    output logic [2*exec_pkg::XLEN-1:0] hilo
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_FINISH
    } state_e;

    state_e           state;
    exec_pkg::md_op_e cmd_q;
    logic [31:0]      a_q, b_q, mag_b;
    logic [63:0]      acc;
    logic [4:0]       count;
    logic             neg_a, neg_b, is_div, sgn, a_neg_n, b_neg_n;
    logic [32:0]      mul_sum;
    logic [33:0]      div_diff;

    assign sgn     = (cmd == exec_pkg::MD_MUL) || (cmd == exec_pkg::MD_DIV);
    assign a_neg_n = sgn && a[31];
    assign b_neg_n = sgn && b[31];
    assign is_div  = (cmd_q == exec_pkg::MD_DIV) || (cmd_q == exec_pkg::MD_DIVU);
    assign busy    = state != S_IDLE;

    // One step of shift-add multiply or restoring divide on magnitudes
    assign mul_sum  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mag_b} : 33'd0);
    assign div_diff = {1'b0, acc[63:31]} - {2'b00, mag_b};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE:   if (start) state <= S_RUN;
                S_RUN:    if (count == 5'd31) state <= S_FINISH;
                S_FINISH: begin
                    state <= S_IDLE;
                    done  <= 1'b1;
                end
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: if (start) begin
                cmd_q <= cmd;
                a_q   <= a;
                b_q   <= b;
                neg_a <= a_neg_n;
                neg_b <= b_neg_n;
                mag_b <= b_neg_n ? -b : b;
                acc   <= {32'd0, a_neg_n ? -a : a};
                count <= '0;
            end
            S_RUN: begin
                count <= count + 5'd1;
                if (!is_div)
                    acc <= {mul_sum, acc[31:1]};
                else if (!div_diff[33])
                    acc <= {div_diff[31:0], acc[30:0], 1'b1};
                else
                    acc <= {acc[62:31], acc[30:0], 1'b0};
            end
            S_FINISH: begin
                if (!is_div)
                    hilo <= (neg_a ^ neg_b) ? -acc : acc;
                else if (b_q == 32'd0)
                    hilo <= {a_q, 32'hffff_ffff};
                else begin
                    hilo[63:32] <= neg_a ? -acc[63:32] : acc[63:32];
                    hilo[31:0]  <= (neg_a ^ neg_b) ? -acc[31:0] : acc[31:0];
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== src.f ====
hw/exec_pkg.sv
hw/exec_ifs.sv
hw/mul_div_unit.sv
hw/inst_decode.sv
hw/alu_exec.sv
hw/hilo_commit.sv
hw/exec_top.sv
test/tb_exec_top.sv

// ==== test/tb_exec_top.sv ====
`timescale 1ns/100ps

module tb_exec_top;

    localparam int N_INSTR        = 400;
    localparam int TIMEOUT_CYCLES = N_INSTR * 40 + 200;

    localparam logic [5:0] R_FN [21] = '{
        exec_pkg::FN_SLL,  exec_pkg::FN_SRL,   exec_pkg::FN_SRA,  exec_pkg::FN_MFHI,
        exec_pkg::FN_MTHI, exec_pkg::FN_MFLO,  exec_pkg::FN_MTLO, exec_pkg::FN_MULT,
        exec_pkg::FN_MULTU, exec_pkg::FN_DIV,  exec_pkg::FN_DIVU, exec_pkg::FN_ADD,
        exec_pkg::FN_ADDU, exec_pkg::FN_SUB,   exec_pkg::FN_SUBU, exec_pkg::FN_AND,
        exec_pkg::FN_OR,   exec_pkg::FN_XOR,   exec_pkg::FN_NOR,  exec_pkg::FN_SLT,
        exec_pkg::FN_SLTU
    };

    localparam logic [5:0] I_OPC [7] = '{
        exec_pkg::OPC_ADDI, exec_pkg::OPC_ADDIU, exec_pkg::OPC_SLTI, exec_pkg::OPC_ANDI,
        exec_pkg::OPC_ORI,  exec_pkg::OPC_XORI,  exec_pkg::OPC_LUI
    };

    typedef struct packed {
        logic [4:0]  dest;
        logic        wen;
        logic [31:0] data;
        logic        ov;
    } beat_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_instr;
    logic [31:0] in_rs_val;
    logic [31:0] in_rt_val;
    logic        out_valid;
    logic        out_ready;
    logic [4:0]  out_dest;
    logic        out_wen;
    logic [31:0] out_data;
    logic        out_overflow;

    logic [31:0] rng_state;
    logic [31:0] hi_m, lo_m;
    beat_t       exp_q[$];
    beat_t       exp_beat;
    int          n_presented, n_accepted, n_checked, cycle_count;

    exec_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .in_rs_val   (in_rs_val),
        .in_rt_val   (in_rt_val),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_dest    (out_dest),
        .out_wen     (out_wen),
        .out_data    (out_data),
        .out_overflow(out_overflow)
    );

    always #5 clk = ~clk;

    task stop_run();
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task report_failure(input string what);
        $display("ERROR: %s (cycle %0d)", what, cycle_count);
        stop_run();
    endtask

    task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s beat %0d: got 0x%0h, expected 0x%0h", name, n_checked, got, exp);
            stop_run();
        end
    endtask

    function logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // A quarter of operands land on the arithmetic corners
    function logic [31:0] pick_operand();
        logic [31:0] r, v;
        r = xorshift();
        case (r[3:2])
            2'd0:    v = 32'h0000_0000;
            2'd1:    v = 32'hffff_ffff;
            2'd2:    v = 32'h8000_0000;
            default: v = 32'h7fff_ffff;
        endcase
        if (r[1:0] != 2'b00)
            v = xorshift();
        return v;
    endfunction

    function automatic logic [31:0] pick_instr(input logic [31:0] k, input logic [31:0] f);
        int sel;
        logic [31:0] w;
        sel = k % 34;
        if (sel < 21)
            w = {exec_pkg::OPC_SPECIAL, f[25:6], R_FN[sel]};
        else if (sel == 21)
            w = {exec_pkg::OPC_SPECIAL2, f[25:6], exec_pkg::FN_CLZ};
        else if (sel == 22)
            w = {exec_pkg::OPC_SPECIAL2, f[25:6], exec_pkg::FN_CLO};
        else if (sel < 30)
            w = {I_OPC[sel - 23], f[25:0]};
        else if (sel == 30)
            w = {exec_pkg::OPC_SPECIAL, f[25:6], 6'h3f};
        else if (sel == 31)
            w = {6'h23, f[25:0]};
        else if (sel == 32)
            w = {exec_pkg::OPC_SPECIAL, f[25:6], exec_pkg::FN_MFHI};
        else
            w = {exec_pkg::OPC_SPECIAL, f[25:6], exec_pkg::FN_MFLO};
        return w;
    endfunction

    function automatic logic [31:0] count_leading(input logic [31:0] v, input logic bitv);
        int n;
        n = 0;
        while (n < 32 && v[31 - n] == bitv)
            n = n + 1;
        return n;
    endfunction

    // True when a wide signed result does not fit in 32 bits
    function automatic logic out_of_range(input longint v);
        return longint'($signed(v[31:0])) != v;
    endfunction

    task automatic model_step(input logic [31:0] instr, input logic [31:0] rs,
                              input logic [31:0] rt);
        logic [5:0]  opc, fn;
        logic [31:0] sx, zx;
        longint      sa, sb, si, q, r;
        logic [63:0] prod;
        beat_t       b;
        opc = instr[31:26];
        fn  = instr[5:0];
        sx  = {{16{instr[15]}}, instr[15:0]};
        zx  = {16'h0000, instr[15:0]};
        sa  = longint'($signed(rs));
        sb  = longint'($signed(rt));
        si  = longint'($signed(sx));
        b   = '0;
        if (opc == exec_pkg::OPC_SPECIAL) begin
            b.dest = instr[15:11];
            case (fn)
                exec_pkg::FN_SLL:  b.data = rt << instr[10:6];
                exec_pkg::FN_SRL:  b.data = rt >> instr[10:6];
                exec_pkg::FN_SRA:  b.data = $signed(rt) >>> instr[10:6];
                exec_pkg::FN_ADD: begin
                    b.data = rs + rt;
                    b.ov   = out_of_range(sa + sb);
                end
                exec_pkg::FN_ADDU: b.data = rs + rt;
                exec_pkg::FN_SUB: begin
                    b.data = rs - rt;
                    b.ov   = out_of_range(sa - sb);
                end
                exec_pkg::FN_SUBU: b.data = rs - rt;
                exec_pkg::FN_AND:  b.data = rs & rt;
                exec_pkg::FN_OR:   b.data = rs | rt;
                exec_pkg::FN_XOR:  b.data = rs ^ rt;
                exec_pkg::FN_NOR:  b.data = ~(rs | rt);
                exec_pkg::FN_SLT:  b.data = {31'd0, sa < sb};
                exec_pkg::FN_SLTU: b.data = {31'd0, rs < rt};
                exec_pkg::FN_MFHI: b.data = hi_m;
                exec_pkg::FN_MFLO: b.data = lo_m;
                exec_pkg::FN_MTHI: begin
                    b.dest = 5'd0;
                    b.data = rs;
                    hi_m   = rs;
                end
                exec_pkg::FN_MTLO: begin
                    b.dest = 5'd0;
                    b.data = rs;
                    lo_m   = rs;
                end
                exec_pkg::FN_MULT, exec_pkg::FN_MULTU: begin
                    b.dest = 5'd0;
                    if (fn == exec_pkg::FN_MULT)
                        prod = sa * sb;
                    else
                        prod = {32'd0, rs} * {32'd0, rt};
                    hi_m = prod[63:32];
                    lo_m = prod[31:0];
                end
                exec_pkg::FN_DIV, exec_pkg::FN_DIVU: begin
                    b.dest = 5'd0;
                    if (rt == 32'd0) begin
                        hi_m = rs;
                        lo_m = 32'hffff_ffff;
                    end else if (fn == exec_pkg::FN_DIV) begin
                        q    = sa / sb;
                        r    = sa % sb;
                        hi_m = r[31:0];
                        lo_m = q[31:0];
                    end else begin
                        hi_m = rs % rt;
                        lo_m = rs / rt;
                    end
                end
                default:           b.dest = 5'd0;
            endcase
        end else if (opc == exec_pkg::OPC_SPECIAL2) begin
            b.dest = instr[15:11];
            if (fn == exec_pkg::FN_CLZ)
                b.data = count_leading(rs, 1'b0);
            else if (fn == exec_pkg::FN_CLO)
                b.data = count_leading(rs, 1'b1);
            else
                b.dest = 5'd0;
        end else begin
            b.dest = instr[20:16];
            case (opc)
                exec_pkg::OPC_ADDI: begin
                    b.data = rs + sx;
                    b.ov   = out_of_range(sa + si);
                end
                exec_pkg::OPC_ADDIU: b.data = rs + sx;
                exec_pkg::OPC_SLTI:  b.data = {31'd0, sa < si};
                exec_pkg::OPC_ANDI:  b.data = rs & zx;
                exec_pkg::OPC_ORI:   b.data = rs | zx;
                exec_pkg::OPC_XORI:  b.data = rs ^ zx;
                exec_pkg::OPC_LUI:   b.data = {instr[15:0], 16'h0000};
                default:             b.dest = 5'd0;
            endcase
        end
        b.wen = (b.dest != 5'd0) && !b.ov;
        exp_q.push_back(b);
    endtask

    // Input acceptance feeds the model, output acceptance is scored
    always @(posedge clk) begin
        if (!rst) begin
            if (in_valid && in_ready) begin
                model_step(in_instr, in_rs_val, in_rt_val);
                n_accepted = n_accepted + 1;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("output beat arrived with no instruction pending");
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_value("out_dest", 64'(out_dest), 64'(exp_beat.dest));
                    check_value("out_wen", 64'(out_wen), 64'(exp_beat.wen));
                    check_value("out_data", 64'(out_data), 64'(exp_beat.data));
                    check_value("out_overflow", 64'(out_overflow), 64'(exp_beat.ov));
                    n_checked = n_checked + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            report_failure("timeout, the DUT stopped producing results");
    end

    initial begin
        logic [31:0] k, f;
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_instr    = 32'd0;
        in_rs_val   = 32'd0;
        in_rt_val   = 32'd0;
        out_ready   = 1'b0;
        rng_state   = 32'h5e0b299d;
        hi_m        = 32'd0;
        lo_m        = 32'd0;
        n_presented = 0;
        n_accepted  = 0;
        n_checked   = 0;
        cycle_count = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("in_ready", 64'(in_ready), 64'd1);

        while (n_checked < N_INSTR) begin
            @(negedge clk);
            // Slot is free once every presented instruction was taken
            if (n_accepted == n_presented) begin
                if (n_presented < N_INSTR && xorshift() % 10 >= 3) begin
                    k         = xorshift();
                    f         = xorshift();
                    in_instr  = pick_instr(k, f);
                    in_rs_val = pick_operand();
                    in_rt_val = pick_operand();
                    in_valid  = 1'b1;
                    n_presented = n_presented + 1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = xorshift() % 10 >= 3;
        end

        // Idle tail to catch duplicated beats
        in_valid = 1'b0;
        repeat (20) begin
            @(negedge clk);
            out_ready = xorshift() % 10 >= 3;
        end
        if (exp_q.size() != 0 || out_valid) begin
            report_failure("a result beat was still pending at the end of the run");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
